//--- verilog/cpuPkg.sv
`default_nettype none
//********************
// Shared types and codes for the multicycle MIPS-subset core
// Referenced by scoped name from the RTL and the testbench
//********************

package cpuPkg;

localparam logic [31:0] resetAddr = 32'h0000_0000;      // Default start address

//********************
// Opcodes and funct codes
//********************
localparam logic [5:0] opRType = 6'h00;                 // Register ops and JR
localparam logic [5:0] opJ     = 6'h02;
localparam logic [5:0] opJal   = 6'h03;
localparam logic [5:0] opBeq   = 6'h04;
localparam logic [5:0] opBne   = 6'h05;
localparam logic [5:0] opAddi  = 6'h08;
localparam logic [5:0] opOri   = 6'h0d;                 // Zero-extended immediate
localparam logic [5:0] opLw    = 6'h23;
localparam logic [5:0] opSw    = 6'h2b;

localparam logic [5:0] fnJr    = 6'h08;
localparam logic [5:0] fnAdd   = 6'h20;
localparam logic [5:0] fnSub   = 6'h22;
localparam logic [5:0] fnAnd   = 6'h24;
localparam logic [5:0] fnOr    = 6'h25;
localparam logic [5:0] fnSlt   = 6'h2a;

//********************
// Selector and state encodings
//********************
typedef enum logic [2:0] {fetchSt, decodeSt, executeSt, memorySt, writeBackSt} ctlState;
typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp;
typedef enum logic [1:0] {pcInc, pcBranch, pcJump, pcReg} pcSelect;
typedef enum logic [1:0] {wbAlu, wbLoad, wbLink} wbSelect;

//********************
// Instruction word views
//********************
typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;                              // Unused by this subset
        logic [5:0] funct;
} rFields;

typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
} iFields;

typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;                            // Word index within region
} jFields;

typedef union packed {
        rFields rForm;
        iFields iForm;
        jFields jForm;
} instrWord;

endpackage

`default_nettype wire

//--- verilog/decodeIf.sv
`timescale 1ns/100ps
`default_nettype none
//********************
// Decoded fields and controls from the decoder to the datapath
//********************

interface decodeIf;
        logic [4:0]      rsAddr;                        // S source register
        logic [4:0]      rtAddr;                        // T source register
        logic [4:0]      rdAddr;                        // Resolved destination
        logic [31:0]     imm;                           // Extended immediate
        logic            useImm;                        // ALU B takes immediate
        cpuPkg::aluOp    aluSel;
        cpuPkg::pcSelect pcSel;                         // Already resolved by compare
        cpuPkg::wbSelect wbSel;
        logic            regWrite;
        logic            memRead;
        logic            memWrite;
        logic [25:0]     jumpTarget;

        modport decSide (output rsAddr, rtAddr, rdAddr, imm, useImm, aluSel,
                         pcSel, wbSel, regWrite, memRead, memWrite, jumpTarget);

        // Read addresses go straight to the register file in the top level
        modport dpSide (input rdAddr, imm, useImm, aluSel, pcSel, wbSel,
                        regWrite, memRead, memWrite, jumpTarget);
endinterface

`default_nettype wire

//--- verilog/cpuControl.sv
`timescale 1ns/100ps
`default_nettype none
//********************
// Master control ring for the multicycle core
// One strobe per state drives the datapath registers
//********************

module cpuControl (
        input  logic            CLK,
        input  logic            MRST,                   // Sync master reset
        output cpuPkg::ctlState state,                  // Present state
        output logic            irLoad,                 // Capture instruction
        output logic            opLoad,                 // Capture operands
        output logic            marLoad,                // Memory access cycle
        output logic            pcLoad,                 // Advance PC
        output logic            wbStrobe                // Register write slot
);

cpuPkg::ctlState nextState;                             // Following state

//********************
// Fixed five-state ring
//********************
always_comb begin
        case (state)
        cpuPkg::fetchSt:     nextState = cpuPkg::decodeSt;
        cpuPkg::decodeSt:    nextState = cpuPkg::executeSt;
        cpuPkg::executeSt:   nextState = cpuPkg::memorySt;
        cpuPkg::memorySt:    nextState = cpuPkg::writeBackSt;
        cpuPkg::writeBackSt: nextState = cpuPkg::fetchSt;
        default:             nextState = cpuPkg::fetchSt;  // Recover from bad code
        endcase
end

always_ff @(posedge CLK) begin
        if (MRST) begin
                state <= cpuPkg::fetchSt;               // Start every run at fetch
        end else begin
                state <= nextState;
        end
end

//********************
// Strobes decoded from present state
//********************
assign irLoad   = (state == cpuPkg::decodeSt);
assign opLoad   = (state == cpuPkg::executeSt);
assign marLoad  = (state == cpuPkg::memorySt);
assign pcLoad   = (state == cpuPkg::writeBackSt);
assign wbStrobe = (state == cpuPkg::writeBackSt);       // Same slot as PC update

endmodule

`default_nettype wire

//--- verilog/decoder.sv
`timescale 1ns/100ps
`default_nettype none
//********************
// Instruction decoder with ALU control and branch quick compare
// Purely combinational from IR and the register read buses
//********************

module decoder (
        input  cpuPkg::instrWord ir,                    // Latched instruction
        input  logic [31:0]      rsData,                // S register bus
        input  logic [31:0]      rtData,                // T register bus
        decodeIf.decSide         dec
);

logic rsEqRt;                                           // Quick compare result

assign rsEqRt = (rsData == rtData);

always_comb begin
        dec.rsAddr     = ir.rForm.rs;                   // Same bits in every view
        dec.rtAddr     = ir.rForm.rt;
        dec.rdAddr     = ir.iForm.rt;                   // I-type writes rt
        dec.imm        = {{16{ir.iForm.imm[15]}}, ir.iForm.imm};
        dec.useImm     = 1'b0;
        dec.aluSel     = cpuPkg::aluAdd;
        dec.pcSel      = cpuPkg::pcInc;
        dec.wbSel      = cpuPkg::wbAlu;
        dec.regWrite   = 1'b0;
        dec.memRead    = 1'b0;
        dec.memWrite   = 1'b0;
        dec.jumpTarget = ir.jForm.target;

        case (ir.rForm.opcode)
        cpuPkg::opRType: begin
                dec.rdAddr   = ir.rForm.rd;
                dec.regWrite = 1'b1;
                case (ir.rForm.funct)
                cpuPkg::fnAdd: dec.aluSel = cpuPkg::aluAdd;
                cpuPkg::fnSub: dec.aluSel = cpuPkg::aluSub;
                cpuPkg::fnAnd: dec.aluSel = cpuPkg::aluAnd;
                cpuPkg::fnOr:  dec.aluSel = cpuPkg::aluOr;
                cpuPkg::fnSlt: dec.aluSel = cpuPkg::aluSlt;
                cpuPkg::fnJr: begin
                        dec.pcSel    = cpuPkg::pcReg;   // Return through rs
                        dec.regWrite = 1'b0;
                end
                default:       dec.regWrite = 1'b0;     // Unknown funct is a no-op
                endcase
        end
        cpuPkg::opAddi: begin
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
        end
        cpuPkg::opOri: begin
                dec.imm      = {16'h0000, ir.iForm.imm};  // Logical op zero-extends
                dec.useImm   = 1'b1;
                dec.aluSel   = cpuPkg::aluOr;
                dec.regWrite = 1'b1;
        end
        cpuPkg::opLw: begin
                dec.useImm   = 1'b1;                    // Base plus offset
                dec.wbSel    = cpuPkg::wbLoad;
                dec.regWrite = 1'b1;
                dec.memRead  = 1'b1;
        end
        cpuPkg::opSw: begin
                dec.useImm   = 1'b1;
                dec.memWrite = 1'b1;
        end
        cpuPkg::opBeq: dec.pcSel = rsEqRt ? cpuPkg::pcBranch : cpuPkg::pcInc;
        cpuPkg::opBne: dec.pcSel = rsEqRt ? cpuPkg::pcInc : cpuPkg::pcBranch;
        cpuPkg::opJ:   dec.pcSel = cpuPkg::pcJump;
        cpuPkg::opJal: begin
                dec.pcSel    = cpuPkg::pcJump;
                dec.rdAddr   = 5'd31;                   // Link register
                dec.wbSel    = cpuPkg::wbLink;
                dec.regWrite = 1'b1;
        end
        default: ;                                      // Unsupported opcode is a no-op
        endcase
end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/100ps
`default_nettype none
//********************
// 32 x 32 register file with two read ports and one write port
//********************

module regFile (
        input  logic        CLK,
        input  logic        MRST,
        input  logic [4:0]  rsAddr,                     // Read port S
        input  logic [4:0]  rtAddr,                     // Read port T
        input  logic [4:0]  wrAddr,
        input  logic        wrEn,                       // Write-back slot only
        input  logic [31:0] wrData,
        output logic [31:0] rsData,
        output logic [31:0] rtData
);

logic [31:0] regs [1:31];                               // No storage for r0

always_ff @(posedge CLK) begin
        if (MRST) begin
                for (int i = 1; i < 32; i++) begin
                        regs[i] <= '0;
                end
        end else if (wrEn && (wrAddr != 5'd0)) begin    // Writes to r0 dropped
                regs[wrAddr] <= wrData;
        end
end

// Reads are combinational
assign rsData = (rsAddr == 5'd0) ? 32'h0 : regs[rsAddr];
assign rtData = (rtAddr == 5'd0) ? 32'h0 : regs[rtAddr];

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/100ps
`default_nettype none
//********************
// Integer ALU for the core subset
// Add, subtract, and, or and signed set-less-than
//********************

module alu (
        input  logic [31:0] a,                          // Latched rs
        input  logic [31:0] b,                          // rt or immediate
        input  cpuPkg::aluOp sel,
        output logic [31:0] y
);

logic [31:0] sum;                                       // a + b
logic [31:0] diff;                                      // a - b
logic        lessThan;                                  // Signed a < b

assign sum  = a + b;
assign diff = a - b;

// Signs differ so the negative one is smaller
// otherwise the difference sign cannot overflow
assign lessThan = (a[31] != b[31]) ? a[31] : diff[31];

always_comb begin
        case (sel)
        cpuPkg::aluAdd: y = sum;
        cpuPkg::aluSub: y = diff;
        cpuPkg::aluAnd: y = a & b;
        cpuPkg::aluOr:  y = a | b;
        cpuPkg::aluSlt: y = {31'h0, lessThan};          // Boolean in bit 0
        default:        y = sum;
        endcase
end

endmodule

`default_nettype wire

//--- verilog/cpuDatapath.sv
`timescale 1ns/100ps
`default_nettype none
//********************
// Datapath registers with next-PC and write-back selection
// Each register loads on its control strobe
//********************

module cpuDatapath #(
        parameter logic [31:0] resetAddr = cpuPkg::resetAddr
) (
        input  logic             CLK,
        input  logic             MRST,
        input  logic             irLoad,
        input  logic             opLoad,
        input  logic             marLoad,               // High in memory state
        input  logic             pcLoad,
        input  logic             wbStrobe,
        decodeIf.dpSide          dec,
        output cpuPkg::instrWord ir,
        input  logic [31:0]      rsData,
        input  logic [31:0]      rtData,
        output logic [4:0]       wrAddr,
        output logic             wrEn,
        output logic [31:0]      wrData,
        output logic [31:0]      aluA,
        output logic [31:0]      aluB,
        output cpuPkg::aluOp     aluSel,
        input  logic [31:0]      aluY,
        input  logic [31:0]      Iin,
        output logic [31:0]      Iaddr,
        output logic [31:0]      Daddr,
        output logic [31:0]      Dout,
        input  logic [31:0]      Din,
        output logic             Dread,
        output logic             Dwrite
);

logic [31:0] pc;                                        // Program counter
logic [31:0] rsLatch, rtLatch;                          // ALU operand latches
logic [31:0] mar;                                       // ALU result and address
logic [31:0] smdr;                                      // Last store data
logic [31:0] loadReg;                                   // Loaded word
logic [31:0] pcPlus4;
logic [31:0] nextPc;

//********************
// Registers
//********************
always_ff @(posedge CLK) begin
        if (MRST) begin
                pc <= resetAddr;
        end else if (pcLoad) begin
                pc <= nextPc;                           // Once per instruction
        end
end

always_ff @(posedge CLK) begin
        if (irLoad) ir <= Iin;
        if (opLoad) begin
                rsLatch <= rsData;
                rtLatch <= rtData;
        end
        if (marLoad) begin
                mar     <= aluY;
                smdr    <= rtLatch;
                loadReg <= Din;                         // Din valid this cycle
        end
end

//********************
// Next PC and write-back
//********************
assign pcPlus4 = pc + 32'd4;

always_comb begin
        case (dec.pcSel)
        cpuPkg::pcBranch: nextPc = pcPlus4 + {dec.imm[29:0], 2'b00};
        cpuPkg::pcJump:   nextPc = {pcPlus4[31:28], dec.jumpTarget, 2'b00};
        cpuPkg::pcReg:    nextPc = rsData;              // JR target
        default:          nextPc = pcPlus4;
        endcase
end

always_comb begin
        case (dec.wbSel)
        cpuPkg::wbLoad: wrData = loadReg;
        cpuPkg::wbLink: wrData = pcPlus4;               // JAL return address
        default:        wrData = mar;
        endcase
end

assign wrAddr = dec.rdAddr;
assign wrEn   = wbStrobe & dec.regWrite;

// ALU operands from the latches
assign aluA   = rsLatch;
assign aluB   = dec.useImm ? dec.imm : rtLatch;
assign aluSel = dec.aluSel;

// Memory buses hold the last access between memory cycles
assign Iaddr  = pc;
assign Daddr  = marLoad ? aluY : mar;
assign Dout   = marLoad ? rtLatch : smdr;
assign Dread  = marLoad & dec.memRead;
assign Dwrite = marLoad & dec.memWrite;

endmodule

`default_nettype wire

//--- verilog/cpu.sv
`timescale 1ns/100ps
`default_nettype none
//********************
// Top level of the multicycle core
// Instruction and data memories attach on plain ports
//********************

module cpu #(
        parameter logic [31:0] resetAddr = cpuPkg::resetAddr  // PC after reset
) (
        input  logic        CLK,
        input  logic        MRST,
        output logic [31:0] Iaddr,                      // Instruction address
        input  logic [31:0] Iin,
        output logic [31:0] Daddr,                      // Data address
        output logic [31:0] Dout,                       // Store data
        input  logic [31:0] Din,                        // Load data
        output logic        Dread,
        output logic        Dwrite
);

cpuPkg::ctlState  state;                                // Present state for debug
cpuPkg::instrWord ir;
cpuPkg::aluOp     aluSel;
logic             irLoad, opLoad, marLoad, pcLoad, wbStrobe;
logic [31:0]      rsData, rtData, wrData;               // Register file buses
logic [4:0]       wrAddr;
logic             wrEn;
logic [31:0]      aluA, aluB, aluY;

decodeIf decBus ();                                     // Decoder to datapath

cpuControl ctl (.CLK, .MRST, .state, .irLoad, .opLoad, .marLoad, .pcLoad, .wbStrobe);

decoder dcd (.ir, .rsData, .rtData, .dec(decBus.decSide));

regFile rf (.CLK, .MRST, .rsAddr(decBus.rsAddr), .rtAddr(decBus.rtAddr), .wrAddr,
            .wrEn, .wrData, .rsData, .rtData);

alu aluUnit (.a(aluA), .b(aluB), .sel(aluSel), .y(aluY));

cpuDatapath #(.resetAddr(resetAddr)) dp (
        .CLK, .MRST, .irLoad, .opLoad, .marLoad, .pcLoad, .wbStrobe,
        .dec(decBus.dpSide), .ir, .rsData, .rtData, .wrAddr, .wrEn, .wrData,
        .aluA, .aluB, .aluSel, .aluY,
        .Iin, .Iaddr, .Daddr, .Dout, .Din, .Dread, .Dwrite
);

endmodule

`default_nettype wire

//--- tests/tbClock.sv
`timescale 1ns/100ps
`default_nettype none
//********************
// Clock and master reset source for the core testbench
//********************

module tbClock #(
        parameter int periodNs    = 4,
        parameter int resetCycles = 16
) (
        output logic CLK,
        output logic MRST
);

initial begin
        CLK = 1'b0;
        forever #(periodNs / 2) CLK = ~CLK;             // Free-running clock
end

initial begin
        MRST = 1'b1;
        repeat (resetCycles) @(posedge CLK);
        MRST <= 1'b0;                                   // Release on a rising edge
end

endmodule

`default_nettype wire

//--- tests/cpuTb.sv
`timescale 1ns/100ps
`default_nettype none
//********************
// Testbench for the multicycle core with memory models and a test program
// Runs until the program reaches its halt loop
//********************

module cpuTb;

localparam logic [31:0] resetAddr = 32'h0000_0100;
localparam int progLen   = 33;
localparam int haltIdx   = 31;                          // J to itself
localparam int numStores = 10;
localparam int timeoutNs = (progLen + 10) * 5 * 4 + 16 * 4;

logic        CLK, MRST;
logic [31:0] Iaddr, Iin, Daddr, Dout, Din;
logic        Dread, Dwrite;
logic [31:0] imem [0:63];
logic [31:0] dmem [0:63];
logic [31:0] opA, opB, opC;                             // Source words
logic [31:0] expAddr [0:numStores-1];
logic [31:0] expData [0:numStores-1];
int          expTest [0:numStores-1];
int          testErr [1:6];
string       testName [1:6];
int          storeIdx, holdCnt, pcIdx, nextIdx, total;
logic [31:0] lastAddr;
integer      seed = 61584;

tbClock clkGen (.CLK, .MRST);

cpu #(.resetAddr(resetAddr)) dut (.CLK, .MRST, .Iaddr, .Iin, .Daddr, .Dout, .Din,
        .Dread, .Dwrite);

// Memories answer combinationally
assign Iin = imem[Iaddr[7:2]];
assign Din = Dread ? dmem[Daddr[7:2]] : 32'h0;          // Data only under Dread

always @(posedge CLK) begin
        if (Dwrite) dmem[Daddr[7:2]] <= Dout;
end

//********************
// Instruction encoders
//********************
function automatic logic [31:0] encR(logic [5:0] fn, int rs, int rt, int rd);
        return {cpuPkg::opRType, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
endfunction

function automatic logic [31:0] encI(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
endfunction

function automatic logic [31:0] encJ(logic [5:0] op, int idx);
        logic [31:0] target;
        target = resetAddr + 32'(idx * 4);              // Byte address of target slot
        return {op, target[27:2]};
endfunction

// Expected successor of a program slot by the branch and jump rules
function automatic int successor(int idx);
        case (idx)
        21:      return (opA == opB) ? 23 : 22;         // BEQ r1,r2
        22:      return 24;                             // BEQ r1,r1 taken
        24:      return 25;                             // BNE r1,r1 falls through
        25:      return (opA != opB) ? 27 : 26;         // BNE r1,r2
        27:      return 29;                             // J
        29:      return 32;                             // JAL
        haltIdx: return haltIdx;                        // Halt loop stays put
        32:      return 30;                             // JR back to link
        default: return idx + 1;
        endcase
endfunction

function automatic int testOfSlot(int idx);
        if (idx >= 21 && idx <= 26) return 5;
        if (idx == 27 || idx == 29 || idx == haltIdx || idx == 32) return 6;
        return 1;
endfunction

task automatic expectStore(int slot, logic [31:0] addr, logic [31:0] data, int test);
        expAddr[slot] = addr;
        expData[slot] = data;
        expTest[slot] = test;
endtask

//********************
// Timing checks
//********************
resetState: assert property (@(posedge CLK) $fell(MRST) |->
                (Iaddr == resetAddr && !Dread && !Dwrite && dut.state == cpuPkg::fetchSt))
        else begin
                $display("Outputs not in reset state after reset release");
                testErr[1]++;
        end

strobeSingle: assert property (@(posedge CLK) disable iff (MRST)
                (Dread || Dwrite) |=> !(Dread || Dwrite))
        else begin
                $display("Memory strobe held longer than one cycle");
                testErr[1]++;
        end

// Hold count and control flow on every Iaddr change
always @(posedge CLK) begin
        if (MRST) begin
                lastAddr = Iaddr;
                holdCnt  = 0;
        end else if (Iaddr != lastAddr) begin
                pcIdx   = int'((lastAddr - resetAddr) >> 2);
                nextIdx = successor(pcIdx);
                assert (holdCnt == 5) else begin
                        $display("[ERROR] %0t Iaddr hold expected 5 got %0d", $time, holdCnt);
                        testErr[1]++;
                end
                assert (Iaddr == resetAddr + 32'(nextIdx * 4)) else begin
                        $display("[ERROR] %0t Iaddr expected %h got %h", $time,
                                 resetAddr + 32'(nextIdx * 4), Iaddr);
                        testErr[testOfSlot(pcIdx)]++;
                end
                lastAddr = Iaddr;
                holdCnt  = 1;
        end else begin
                holdCnt++;
        end
end

// Store monitor
always @(posedge CLK) begin
        if (!MRST && Dwrite) begin
                assert (storeIdx < numStores) else begin
                        $display("Unexpected extra store at %0t", $time);
                        testErr[1]++;
                end
                if (storeIdx < numStores) begin
                        assert (Daddr == expAddr[storeIdx]) else begin
                                $display("[ERROR] %0t Daddr expected %h got %h", $time,
                                         expAddr[storeIdx], Daddr);
                                testErr[expTest[storeIdx]]++;
                        end
                        assert (Dout == expData[storeIdx]) else begin
                                $display("[ERROR] %0t Dout expected %h got %h", $time,
                                         expData[storeIdx], Dout);
                                testErr[expTest[storeIdx]]++;
                        end
                end
                storeIdx++;
        end
end

//********************
// Watchdog
//********************
initial begin
        #(timeoutNs);
        $display("Timeout: program did not reach its halt loop in %0d ns", timeoutNs);
        $display("SOME TESTS FAILED");
        $finish;
end

//********************
// Program and run
//********************
initial begin
        testName = '{"reset and sequencing", "register arithmetic", "immediates and r0",
                     "memory round trip", "branches", "jumps and link"};
        for (int t = 1; t <= 6; t++) testErr[t] = 0;
        storeIdx = 0;
        for (int i = 0; i < 64; i++) begin
                dmem[i] <= $random(seed);               // Seeded data words
                imem[i] = 32'h0;                        // Zero word acts as no-op
        end
        @(posedge CLK);                                 // Data words settle in reset
        opA = dmem[0];
        opB = dmem[1];
        opC = dmem[2];

        imem[0]  = encI(cpuPkg::opLw, 0, 1, 16'h0000);
        imem[1]  = encI(cpuPkg::opLw, 0, 2, 16'h0004);
        imem[2]  = encR(cpuPkg::fnAdd, 1, 2, 3);
        imem[3]  = encI(cpuPkg::opSw, 0, 3, 16'h0080);
        imem[4]  = encR(cpuPkg::fnSub, 1, 2, 3);
        imem[5]  = encI(cpuPkg::opSw, 0, 3, 16'h0084);
        imem[6]  = encR(cpuPkg::fnAnd, 1, 2, 3);
        imem[7]  = encI(cpuPkg::opSw, 0, 3, 16'h0088);
        imem[8]  = encR(cpuPkg::fnOr, 1, 2, 3);
        imem[9]  = encI(cpuPkg::opSw, 0, 3, 16'h008c);
        imem[10] = encR(cpuPkg::fnSlt, 1, 2, 3);
        imem[11] = encI(cpuPkg::opSw, 0, 3, 16'h0090);
        imem[12] = encI(cpuPkg::opAddi, 0, 4, 16'hfffd); // Minus three
        imem[13] = encI(cpuPkg::opSw, 0, 4, 16'h0094);
        imem[14] = encI(cpuPkg::opOri, 0, 5, 16'h8001);  // High bit set
        imem[15] = encI(cpuPkg::opSw, 0, 5, 16'h0098);
        imem[16] = encI(cpuPkg::opAddi, 0, 0, 16'h0005); // Write to r0
        imem[17] = encI(cpuPkg::opSw, 0, 0, 16'h009c);
        imem[18] = encI(cpuPkg::opLw, 0, 6, 16'h0008);
        imem[19] = encI(cpuPkg::opAddi, 0, 7, 16'h0010);
        imem[20] = encI(cpuPkg::opSw, 7, 6, 16'h00a0);   // Copy to 0xb0
        imem[21] = encI(cpuPkg::opBeq, 1, 2, 16'h0001);
        imem[22] = encI(cpuPkg::opBeq, 1, 1, 16'h0001);
        imem[23] = encI(cpuPkg::opAddi, 0, 0, 16'h0001); // Skipped slot
        imem[24] = encI(cpuPkg::opBne, 1, 1, 16'h0001);
        imem[25] = encI(cpuPkg::opBne, 1, 2, 16'h0001);
        imem[26] = encI(cpuPkg::opAddi, 0, 0, 16'h0001);
        imem[27] = encJ(cpuPkg::opJ, 29);
        imem[28] = encI(cpuPkg::opSw, 0, 0, 16'h00fc);   // Must never run
        imem[29] = encJ(cpuPkg::opJal, 32);
        imem[30] = encI(cpuPkg::opSw, 0, 31, 16'h00b4);
        imem[31] = encJ(cpuPkg::opJ, haltIdx);
        imem[32] = encR(cpuPkg::fnJr, 31, 0, 0);

        expectStore(0, 32'h80, opA + opB, 2);
        expectStore(1, 32'h84, opA - opB, 2);
        expectStore(2, 32'h88, opA & opB, 2);
        expectStore(3, 32'h8c, opA | opB, 2);
        expectStore(4, 32'h90, ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0, 2);
        expectStore(5, 32'h94, 32'hffff_fffd, 3);
        expectStore(6, 32'h98, 32'h0000_8001, 3);
        expectStore(7, 32'h9c, 32'h0, 3);
        expectStore(8, 32'hb0, opC, 4);
        expectStore(9, 32'hb4, resetAddr + 32'd29 * 4 + 4, 6);  // JAL slot plus 4

        @(negedge MRST);
        while (Iaddr != resetAddr + 32'(haltIdx * 4)) @(posedge CLK);
        repeat (10) @(posedge CLK);                     // Let the halt loop settle

        assert (storeIdx == numStores) else begin
                $display("Store count wrong, %0d seen and %0d expected", storeIdx, numStores);
                testErr[1]++;
        end
        total = 0;
        for (int t = 1; t <= 6; t++) begin
                $display("Test %0d %s: %s", t, testName[t], (testErr[t] == 0) ? "ok" : "failed");
                total += testErr[t];
        end
        $display("Tests run 6, errors %0d, stores %0d", total, storeIdx);
        if (total == 0) begin
                $display("ALL TESTS PASSED");
        end else begin
                $display("SOME TESTS FAILED");
        end
        $finish;
end

endmodule

`default_nettype wire

//--- tb.f
verilog/cpuPkg.sv
verilog/decodeIf.sv
verilog/cpuControl.sv
verilog/decoder.sv
verilog/regFile.sv
verilog/alu.sv
verilog/cpuDatapath.sv
verilog/cpu.sv
tests/tbClock.sv
tests/cpuTb.sv

//--- Makefile
# Verilator build and run for the multicycle core testbench

VERILATOR ?= verilator
TOP       ?= cpuTb
RTL_TOP   ?= cpu
FILELIST  ?= tb.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
